// ==== tb.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/fetch_latch.sv
hdl/instr_decoder.sv
hdl/instr_queue.sv
hdl/decode_front.sv
bench/tb_decode_front.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode front end testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f tb.f \
	--top-module tb_decode_front \
	--Mdir obj_dir \
	-o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== bench/tb_decode_front.sv ====
/*
 * Testbench for the decode front end. Drives xorshift instruction streams through
 * fetch, decodes them again in a reference model and scoreboards the issued entries.
 */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module tb_decode_front;

	localparam int N_INSTR = 400;
	localparam int CYCLE_LIMIT = N_INSTR * 40 + 4;

	logic                      clk;
	logic                      rst;
	logic                      fetch_valid;
	decode_pkg::instr_word_u   fetch_instr;
	logic [`XLEN-1:0]          fetch_pc;
	logic                      fetch_stall;
	logic                      issue_pop;
	logic                      issue_valid;
	decode_pkg::micro_instr_t  issue_instr;

	decode_pkg::micro_instr_t  sb [$];
	logic [31:0]               rng;
	logic [31:0]               cur_word;
	logic [`XLEN-1:0]          cur_pc;
	logic                      have_instr;
	logic                      took;
	int                        gen_count;
	int                        accepted;
	int                        issued;
	int                        bp_accepts;
	int                        checks;
	int                        errors;
	int                        cycles;
	int                        phase_err;
	int                        phase_chk;
	bit                        no_pop_phase;
	bit                        full_rate_phase;
	string                     test_name;

	decode_front u_decode_front (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		.fetch_stall (fetch_stall),
		.issue_pop   (issue_pop),
		.issue_valid (issue_valid),
		.issue_instr (issue_instr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// random template over the supported kinds, register and immediate bits stay random
	function automatic logic [31:0] make_word();
		logic [31:0] w;
		logic [31:0] r;
		logic [2:0] f3_br [6];
		logic [2:0] f3_w [3];
		logic [2:0] f3_csr [6];
		f3_br = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		f3_w = '{3'd0, 3'd1, 3'd5};
		f3_csr = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
		w = rand32();
		r = rand32();
		if (r % 100 < 5) begin
			return w;
		end
		r = rand32();
		case (r % 15)
			0: w[6:0] = 7'h37;
			1: w[6:0] = 7'h17;
			2: w[6:0] = 7'h6f;
			3: begin
				w[6:0] = 7'h67;
				w[14:12] = 3'd0;
			end
			4: begin
				w[6:0] = 7'h63;
				w[14:12] = f3_br[(r >> 4) % 6];
			end
			5: begin
				w[6:0] = 7'h03;
				w[14:12] = 3'((r >> 4) % 7);
			end
			6: begin
				w[6:0] = 7'h23;
				w[14:12] = 3'((r >> 4) % 4);
			end
			7: begin
				w[6:0] = 7'h13;
				if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
					w[31:26] = (r[8] && w[14:12] == 3'd5) ? 6'b010000 : 6'b000000;
				end
			end
			8, 10: begin
				w[6:0] = (r % 15 == 8) ? 7'h1b : 7'h3b;
				w[14:12] = f3_w[(r >> 4) % 3];
				w[31:25] = (r[8] && w[14:12] != 3'd1) ? 7'h20 : 7'h00;
			end
			9: begin
				w[6:0] = 7'h33;
				w[31:25] = (r[8] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
			end
			11: begin
				w[6:0] = 7'h0f;
				w[14:12] = {2'b00, r[8]};
			end
			12: begin
				w[6:0] = 7'h73;
				w[14:12] = 3'd0;
				w[31:20] = {11'd0, r[8]};
			end
			13: begin
				w[6:0] = 7'h73;
				w[14:12] = f3_csr[(r >> 4) % 6];
			end
			default: w = 32'h3020_0073;
		endcase
		return w;
	endfunction

	// reference decode straight from the RV64I, Zicsr and Zifencei encodings
	function automatic decode_pkg::micro_instr_t ref_decode(input decode_pkg::instr_word_u w,
			input logic [`XLEN-1:0] pc);
		decode_pkg::micro_instr_t e;
		logic [2:0] f3;
		logic [6:0] f7;
		int fmt;
		bit no_rd;
		e = '0;
		fmt = 0;
		no_rd = 0;
		f3 = w.r.funct3;
		f7 = w.r.funct7;
		case (w.r.opcode)
			7'h37: begin e.op.rv64i_lui = 1'b1; fmt = 4; end
			7'h17: begin e.op.rv64i_auipc = 1'b1; fmt = 4; end
			7'h6f: begin e.op.rv64i_jal = 1'b1; fmt = 5; end
			7'h67: if (f3 == 3'd0) begin e.op.rv64i_jalr = 1'b1; fmt = 1; end
			7'h63: begin
				fmt = 3;
				no_rd = 1;
				case (f3)
					3'd0: e.op.rv64i_beq = 1'b1;
					3'd1: e.op.rv64i_bne = 1'b1;
					3'd4: e.op.rv64i_blt = 1'b1;
					3'd5: e.op.rv64i_bge = 1'b1;
					3'd6: e.op.rv64i_bltu = 1'b1;
					3'd7: e.op.rv64i_bgeu = 1'b1;
					default: begin fmt = 0; no_rd = 0; end
				endcase
			end
			7'h03: begin
				fmt = 1;
				case (f3)
					3'd0: e.op.rv64i_lb = 1'b1;
					3'd1: e.op.rv64i_lh = 1'b1;
					3'd2: e.op.rv64i_lw = 1'b1;
					3'd3: e.op.rv64i_ld = 1'b1;
					3'd4: e.op.rv64i_lbu = 1'b1;
					3'd5: e.op.rv64i_lhu = 1'b1;
					3'd6: e.op.rv64i_lwu = 1'b1;
					default: fmt = 0;
				endcase
			end
			7'h23: begin
				fmt = 2;
				no_rd = 1;
				case (f3)
					3'd0: e.op.rv64i_sb = 1'b1;
					3'd1: e.op.rv64i_sh = 1'b1;
					3'd2: e.op.rv64i_sw = 1'b1;
					3'd3: e.op.rv64i_sd = 1'b1;
					default: begin fmt = 0; no_rd = 0; end
				endcase
			end
			7'h13: begin
				fmt = 1;
				case (f3)
					3'd0: e.op.rv64i_addi = 1'b1;
					3'd2: e.op.rv64i_slti = 1'b1;
					3'd3: e.op.rv64i_sltiu = 1'b1;
					3'd4: e.op.rv64i_xori = 1'b1;
					3'd6: e.op.rv64i_ori = 1'b1;
					3'd7: e.op.rv64i_andi = 1'b1;
					3'd1: e.op.rv64i_slli = (f7[6:1] == 6'b000000);
					default: begin
						e.op.rv64i_srli = (f7[6:1] == 6'b000000);
						e.op.rv64i_srai = (f7[6:1] == 6'b010000);
					end
				endcase
				if (e.op == '0) fmt = 0;
			end
			7'h1b: begin
				e.op.rv64i_addiw = (f3 == 3'd0);
				e.op.rv64i_slliw = (f3 == 3'd1) && (f7 == 7'h00);
				e.op.rv64i_srliw = (f3 == 3'd5) && (f7 == 7'h00);
				e.op.rv64i_sraiw = (f3 == 3'd5) && (f7 == 7'h20);
				fmt = (e.op != '0) ? 1 : 0;
			end
			7'h33: case ({f7, f3})
				{7'h00, 3'd0}: e.op.rv64i_add = 1'b1;
				{7'h20, 3'd0}: e.op.rv64i_sub = 1'b1;
				{7'h00, 3'd1}: e.op.rv64i_sll = 1'b1;
				{7'h00, 3'd2}: e.op.rv64i_slt = 1'b1;
				{7'h00, 3'd3}: e.op.rv64i_sltu = 1'b1;
				{7'h00, 3'd4}: e.op.rv64i_xor = 1'b1;
				{7'h00, 3'd5}: e.op.rv64i_srl = 1'b1;
				{7'h20, 3'd5}: e.op.rv64i_sra = 1'b1;
				{7'h00, 3'd6}: e.op.rv64i_or = 1'b1;
				{7'h00, 3'd7}: e.op.rv64i_and = 1'b1;
				default: ;
			endcase
			7'h3b: case ({f7, f3})
				{7'h00, 3'd0}: e.op.rv64i_addw = 1'b1;
				{7'h20, 3'd0}: e.op.rv64i_subw = 1'b1;
				{7'h00, 3'd1}: e.op.rv64i_sllw = 1'b1;
				{7'h00, 3'd5}: e.op.rv64i_srlw = 1'b1;
				{7'h20, 3'd5}: e.op.rv64i_sraw = 1'b1;
				default: ;
			endcase
			7'h0f: if (f3 <= 3'd1) begin
				e.op.rv64i_fence = (f3 == 3'd0);
				e.op.rv64zi_fence_i = (f3 == 3'd1);
				fmt = 1;
				no_rd = 1;
			end
			7'h73: case (f3)
				3'd0: begin
					e.op.rv64i_ecall = (w.i.imm12 == 12'h000);
					e.op.rv64i_ebreak = (w.i.imm12 == 12'h001);
					no_rd = e.op.rv64i_ecall | e.op.rv64i_ebreak;
				end
				3'd4: ;
				default: begin
					fmt = 1;
					e.op.rv64csr_rw = (f3 == 3'd1);
					e.op.rv64csr_rs = (f3 == 3'd2);
					e.op.rv64csr_rc = (f3 == 3'd3);
					e.op.rv64csr_rwi = (f3 == 3'd5);
					e.op.rv64csr_rsi = (f3 == 3'd6);
					e.op.rv64csr_rci = (f3 == 3'd7);
				end
			endcase
			default: ;
		endcase
		e.op.privil_mret = (w == 32'h3020_0073);
		case (fmt)
			1: e.imm = {{52{w[31]}}, w[31:20]};
			2: e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
			3: e.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			4: e.imm = {{32{w[31]}}, w[31:12], 12'b0};
			5: e.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: e.imm = '0;
		endcase
		e.pc = pc;
		e.shamt = {w[25], w[24:20]};
		e.rd0 = no_rd ? 5'd0 : w[11:7];
		e.rs1 = w[19:15];
		e.rs2 = w[24:20];
		return e;
	endfunction

	// negedge sampling sees settled inputs and outputs for the coming edge
	always @(negedge clk) begin
		decode_pkg::micro_instr_t exp;
		took = 1'b0;
		if (!rst) begin
			if (fetch_valid && !fetch_stall) begin
				took = 1'b1;
				accepted++;
				sb.push_back(ref_decode(fetch_instr, fetch_pc));
				if (no_pop_phase) begin
					bp_accepts++;
					checks++;
					assert (bp_accepts <= `INSTR_Q_DEPTH + 1) else begin
						$display("%s: %0d accepted with no pops, stall came too late",
							test_name, bp_accepts);
						errors++;
					end
				end
			end
			if (full_rate_phase) begin
				checks++;
				assert (fetch_stall == 1'b0) else begin
					$display("mismatch %s fetch_stall expected 0 actual %b",
						test_name, fetch_stall);
					errors++;
				end
			end
			if (issue_valid && issue_pop) begin
				issued++;
				if (sb.size() == 0) begin
					$display("%s: issue with nothing accepted, pc %h", test_name,
						issue_instr.pc);
					errors++;
				end else begin
					exp = sb.pop_front();
					checks++;
					assert (issue_instr.op == exp.op) else begin
						$display("mismatch %s op expected %h actual %h", test_name,
							exp.op, issue_instr.op);
						errors++;
					end
					assert (issue_instr.imm == exp.imm && issue_instr.shamt == exp.shamt)
					else begin
						$display("mismatch %s imm/shamt expected %h/%h actual %h/%h",
							test_name, exp.imm, exp.shamt, issue_instr.imm,
							issue_instr.shamt);
						errors++;
					end
					assert (issue_instr.rd0 == exp.rd0 && issue_instr.rs1 == exp.rs1
						&& issue_instr.rs2 == exp.rs2) else begin
						$display("mismatch %s rd0/rs1/rs2 expected %h actual %h", test_name,
							{exp.rd0, exp.rs1, exp.rs2},
							{issue_instr.rd0, issue_instr.rs1, issue_instr.rs2});
						errors++;
					end
					assert (issue_instr.pc == exp.pc) else begin
						$display("mismatch %s pc expected %h actual %h", test_name,
							exp.pc, issue_instr.pc);
						errors++;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d issued", cycles, issued, N_INSTR);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic next_instr();
		if (gen_count < N_INSTR) begin
			cur_word = make_word();
			cur_pc = cur_pc + 4;
			gen_count++;
			have_instr = 1'b1;
		end else begin
			have_instr = 1'b0;
		end
	endtask

	task automatic step(input int valid_pct, input int pop_pct);
		@(posedge clk);
		#2;
		if (took) begin
			next_instr();
		end
		fetch_valid = have_instr && (rand32() % 100 < valid_pct);
		fetch_instr = cur_word;
		fetch_pc = cur_pc;
		issue_pop = (rand32() % 100 < pop_pct);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		phase_err = errors;
		phase_chk = checks;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d errors", test_name, checks - phase_chk,
			errors - phase_err);
	endtask

	task automatic check_quiet();
		checks++;
		assert (issue_valid === 1'b0 && fetch_stall === 1'b0) else begin
			$display("mismatch %s valid/stall expected 00 actual %b%b", test_name,
				issue_valid, fetch_stall);
			errors++;
		end
	endtask

	initial begin
		rng = 32'h41cae710;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_instr = '0;
		fetch_pc = '0;
		issue_pop = 1'b0;
		{took, gen_count, accepted, issued, bp_accepts, checks, errors, cycles} = '0;
		{no_pop_phase, full_rate_phase} = '0;
		cur_pc = {rand32(), rand32() & 32'hffff_fffc} - 4;
		next_instr();

		begin_test("reset");
		repeat (4) begin
			@(posedge clk);
			#2;
			check_quiet();
		end
		rst = 1'b0;
		@(posedge clk);
		#2;
		check_quiet();
		end_test();

		begin_test("random_pop");
		while (accepted < 150) step(70, 60);
		end_test();

		// queue and latch fill up, then pops resume
		begin_test("backpressure");
		no_pop_phase = 1'b1;
		repeat (25) step(100, 0);
		checks++;
		assert (fetch_stall == 1'b1) else begin
			$display("%s: fetch_stall stayed low with a full queue", test_name);
			errors++;
		end
		no_pop_phase = 1'b0;
		while (accepted < 230) step(70, 80);
		while (sb.size() != 0) step(0, 100);
		end_test();

		begin_test("full_throughput");
		full_rate_phase = 1'b1;
		while (accepted < 320) step(100, 100);
		full_rate_phase = 1'b0;
		end_test();

		begin_test("slow_pop");
		while (accepted < N_INSTR) step(70, 25);
		while (sb.size() != 0) step(0, 100);
		repeat (10) step(0, 100);
		checks++;
		assert (issued == N_INSTR && !issue_valid) else begin
			$display("%s: %0d issued of %0d accepted", test_name, issued, accepted);
			errors++;
		end
		end_test();

		$display("totals: %0d checks, %0d errors, %0d issued", checks, errors, issued);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/decode_front.sv ====
/*
 * Decode front end top: fetch latch, decoder and instruction queue in a row.
 * Fetch is throttled by fetch_stall, issue pulls with issue_pop.
 */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module decode_front (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_valid,
	input  wire decode_pkg::instr_word_u fetch_instr,
	input  wire [`XLEN-1:0]              fetch_pc,
	output logic                         fetch_stall,
	input  wire                          issue_pop,
	output logic                         issue_valid,
	output decode_pkg::micro_instr_t     issue_instr
);

	wire                           entry_valid;
	wire decode_pkg::fetch_entry_t entry;
	wire                           q_full;
	wire                           q_push;
	wire decode_pkg::micro_instr_t q_data;

	fetch_latch u_fetch_latch (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		// a push into the queue frees the latch
		.entry_taken (q_push),
		.entry_valid (entry_valid),
		.entry       (entry),
		.fetch_stall (fetch_stall)
	);

	instr_decoder u_instr_decoder (
		.entry_valid (entry_valid),
		.entry       (entry),
		.q_full      (q_full),
		.q_push      (q_push),
		.q_data      (q_data)
	);

	instr_queue #(
		.DEPTH (`INSTR_Q_DEPTH)
	) u_instr_queue (
		.clk         (clk),
		.rst         (rst),
		.q_push      (q_push),
		.q_data      (q_data),
		.q_full      (q_full),
		.issue_pop   (issue_pop),
		.issue_valid (issue_valid),
		.issue_instr (issue_instr)
	);

endmodule

`default_nettype wire

// ==== hdl/instr_queue.sv ====
/*
 * Circular FIFO of decoded micro-instructions ahead of issue.
 * Full is taken from the registered count, so a pop does not free a slot early.
 */
`timescale 1ns/1ns
`default_nettype none

module instr_queue #(
	parameter int DEPTH = 4
) (
	input  wire                             clk,
	input  wire                             rst,
	input  wire                             q_push,
	input  wire decode_pkg::micro_instr_t   q_data,
	output logic                            q_full,
	input  wire                             issue_pop,
	output logic                            issue_valid,
	output decode_pkg::micro_instr_t        issue_instr
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	decode_pkg::micro_instr_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign q_full      = (count == (PTR_W + 1)'(DEPTH));
	assign issue_valid = (count != '0);
	assign issue_instr = mem[rd_ptr];

	assign do_push = q_push & ~q_full;
	assign do_pop  = issue_pop & issue_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// simultaneous push and pop leave the count alone
			if (do_push & ~do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop & ~do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= q_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
/*
 * Combinational RV64I/Zicsr/Zifencei decoder. Turns the latched word into a
 * micro-instruction and pushes it into the queue when there is room.
 */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module instr_decoder (
	input  wire                           entry_valid,
	input  wire decode_pkg::fetch_entry_t entry,
	input  wire                           q_full,
	output logic                          q_push,
	output decode_pkg::micro_instr_t      q_data
);

	wire decode_pkg::instr_word_u instr = entry.instr;

	wire [6:0] opcode = instr.r.opcode;
	wire [2:0] funct3 = instr.r.funct3;
	wire [6:0] funct7 = instr.r.funct7;

	// major opcode split into its three fields
	wire [1:0] opc_high = opcode[6:5];
	wire [2:0] opc_mid  = opcode[4:2];
	wire       word32   = (opcode[1:0] == 2'b11);

	wire op_load     = word32 & (opc_high == 2'b00) & (opc_mid == 3'b000);
	wire op_misc_mem = word32 & (opc_high == 2'b00) & (opc_mid == 3'b011);
	wire op_op_imm   = word32 & (opc_high == 2'b00) & (opc_mid == 3'b100);
	wire op_auipc    = word32 & (opc_high == 2'b00) & (opc_mid == 3'b101);
	wire op_op_imm32 = word32 & (opc_high == 2'b00) & (opc_mid == 3'b110);
	wire op_store    = word32 & (opc_high == 2'b01) & (opc_mid == 3'b000);
	wire op_op       = word32 & (opc_high == 2'b01) & (opc_mid == 3'b100);
	wire op_lui      = word32 & (opc_high == 2'b01) & (opc_mid == 3'b101);
	wire op_op_32    = word32 & (opc_high == 2'b01) & (opc_mid == 3'b110);
	wire op_branch   = word32 & (opc_high == 2'b11) & (opc_mid == 3'b000);
	wire op_jalr     = word32 & (opc_high == 2'b11) & (opc_mid == 3'b001);
	wire op_jal      = word32 & (opc_high == 2'b11) & (opc_mid == 3'b011);
	wire op_system   = word32 & (opc_high == 2'b11) & (opc_mid == 3'b100);

	// funct3 as one-hot, f3[n] means funct3 == n
	wire [7:0] f3 = 8'b1 << funct3;
	wire f7_zero = (funct7 == 7'b0000000);
	wire f7_alt  = (funct7 == 7'b0100000);

	// 64-bit shifts give funct7[0] to shamt[5]
	wire sh64_log = (funct7[6:1] == 6'b000000);
	wire sh64_ari = (funct7[6:1] == 6'b010000);

	wire rv64i_beq  = op_branch & f3[0];
	wire rv64i_bne  = op_branch & f3[1];
	wire rv64i_blt  = op_branch & f3[4];
	wire rv64i_bge  = op_branch & f3[5];
	wire rv64i_bltu = op_branch & f3[6];
	wire rv64i_bgeu = op_branch & f3[7];
	wire any_branch = rv64i_beq | rv64i_bne | rv64i_blt | rv64i_bge | rv64i_bltu | rv64i_bgeu;

	wire rv64i_sb  = op_store & f3[0];
	wire rv64i_sh  = op_store & f3[1];
	wire rv64i_sw  = op_store & f3[2];
	wire rv64i_sd  = op_store & f3[3];
	wire any_store = rv64i_sb | rv64i_sh | rv64i_sw | rv64i_sd;

	wire rv64i_jalr = op_jalr & f3[0];
	wire [6:0] loads = {op_load & f3[0], op_load & f3[1], op_load & f3[2], op_load & f3[3],
		op_load & f3[4], op_load & f3[5], op_load & f3[6]};

	wire [12:0] imm_alu = {
		op_op_imm & f3[0], op_op_imm32 & f3[0], op_op_imm & f3[2], op_op_imm & f3[3],
		op_op_imm & f3[4], op_op_imm & f3[6], op_op_imm & f3[7],
		op_op_imm & f3[1] & sh64_log, op_op_imm32 & f3[1] & f7_zero,
		op_op_imm & f3[5] & sh64_log, op_op_imm32 & f3[5] & f7_zero,
		op_op_imm & f3[5] & sh64_ari, op_op_imm32 & f3[5] & f7_alt};

	// add addw sub subw sll sllw slt sltu xor srl srlw sra sraw or and
	wire [14:0] reg_alu = {
		op_op & f3[0] & f7_zero, op_op_32 & f3[0] & f7_zero,
		op_op & f3[0] & f7_alt, op_op_32 & f3[0] & f7_alt,
		op_op & f3[1] & f7_zero, op_op_32 & f3[1] & f7_zero,
		op_op & f3[2] & f7_zero, op_op & f3[3] & f7_zero, op_op & f3[4] & f7_zero,
		op_op & f3[5] & f7_zero, op_op_32 & f3[5] & f7_zero,
		op_op & f3[5] & f7_alt, op_op_32 & f3[5] & f7_alt,
		op_op & f3[6] & f7_zero, op_op & f3[7] & f7_zero};

	wire rv64i_fence    = op_misc_mem & f3[0];
	wire rv64zi_fence_i = op_misc_mem & f3[1];
	wire rv64i_ecall    = op_system & f3[0] & (instr.i.imm12 == 12'h000);
	wire rv64i_ebreak   = op_system & f3[0] & (instr.i.imm12 == 12'h001);
	wire [5:0] csr_ops  = {op_system & f3[1], op_system & f3[2], op_system & f3[3],
		op_system & f3[5], op_system & f3[6], op_system & f3[7]};

	// mret only as its exact encoding
	wire privil_mret = (instr == 32'h3020_0073);

	wire [`MICRO_OP_FLAGS-1:0] op_vec = {
		op_lui, op_auipc, op_jal, rv64i_jalr,
		rv64i_beq, rv64i_bne, rv64i_blt, rv64i_bge, rv64i_bltu, rv64i_bgeu,
		loads, rv64i_sb, rv64i_sh, rv64i_sw, rv64i_sd,
		imm_alu, reg_alu,
		rv64i_fence, rv64zi_fence_i,
		rv64i_ecall, rv64i_ebreak, csr_ops,
		privil_mret,
		1'b0};

	// format groups for the immediate, R type falls through to zero
	wire fmt_i = rv64i_jalr | (|loads) | (|imm_alu) | rv64i_fence | rv64zi_fence_i | (|csr_ops);
	wire fmt_u = op_lui | op_auipc;

	wire [`XLEN-1:0] imm_i = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
	wire [`XLEN-1:0] imm_s = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	wire [`XLEN-1:0] imm_b = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11,
		instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	wire [`XLEN-1:0] imm_u = {{(`XLEN-32){instr.u.imm20[19]}}, instr.u.imm20, 12'b0};
	wire [`XLEN-1:0] imm_j = {{(`XLEN-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
		instr.j.imm10_1, 1'b0};

	wire [`XLEN-1:0] imm = ({`XLEN{fmt_i}} & imm_i)
		| ({`XLEN{any_store}} & imm_s)
		| ({`XLEN{any_branch}} & imm_b)
		| ({`XLEN{fmt_u}} & imm_u)
		| ({`XLEN{op_jal}} & imm_j);

	// these write no register
	wire no_rd = any_branch | any_store | rv64i_fence | rv64zi_fence_i
		| rv64i_ecall | rv64i_ebreak;

	assign q_data.op    = op_vec;
	assign q_data.pc    = entry.pc;
	assign q_data.imm   = imm;
	assign q_data.shamt = {funct7[0], instr.r.rs2};
	assign q_data.rd0   = no_rd ? '0 : instr.r.rd;
	assign q_data.rs1   = instr.r.rs1;
	assign q_data.rs2   = instr.r.rs2;

	assign q_push = entry_valid & ~q_full;

endmodule

`default_nettype wire

// ==== hdl/fetch_latch.sv ====
/*
 * One-entry register between fetch and decode.
 * Holds its instruction until decode hands it to the queue.
 */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module fetch_latch (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_valid,
	input  wire decode_pkg::instr_word_u fetch_instr,
	input  wire [`XLEN-1:0]              fetch_pc,
	input  wire                          entry_taken,
	output logic                         entry_valid,
	output decode_pkg::fetch_entry_t     entry,
	output logic                         fetch_stall
);

	logic load;

	// the held entry is stuck unless decode moves it this cycle
	assign fetch_stall = entry_valid & ~entry_taken;

	// room when empty or when the current entry leaves now
	assign load = fetch_valid & ~fetch_stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= 1'b0;
		end else if (load) begin
			entry_valid <= 1'b1;
		end else if (entry_taken) begin
			entry_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			entry.instr <= fetch_instr;
			entry.pc <= fetch_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/decode_pkg.sv ====
/*
 * Types for the decode front end: the instruction word in its six layouts,
 * the one-hot micro-op flags and the entries moved between the stages.
 */
`default_nettype none
`include "decode_consts.svh"

package decode_pkg;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset is scattered, bit 0 is implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_word_u;

	// one-hot flags, msb first, grouped by instruction class
	typedef struct packed {
		logic rv64i_lui, rv64i_auipc, rv64i_jal, rv64i_jalr;
		logic rv64i_beq, rv64i_bne, rv64i_blt, rv64i_bge, rv64i_bltu, rv64i_bgeu;
		logic rv64i_lb, rv64i_lh, rv64i_lw, rv64i_ld, rv64i_lbu, rv64i_lhu, rv64i_lwu;
		logic rv64i_sb, rv64i_sh, rv64i_sw, rv64i_sd;
		logic rv64i_addi, rv64i_addiw, rv64i_slti, rv64i_sltiu, rv64i_xori;
		logic rv64i_ori, rv64i_andi, rv64i_slli, rv64i_slliw, rv64i_srli;
		logic rv64i_srliw, rv64i_srai, rv64i_sraiw;
		logic rv64i_add, rv64i_addw, rv64i_sub, rv64i_subw, rv64i_sll, rv64i_sllw;
		logic rv64i_slt, rv64i_sltu, rv64i_xor, rv64i_srl, rv64i_srlw, rv64i_sra;
		logic rv64i_sraw, rv64i_or, rv64i_and;
		logic rv64i_fence, rv64zi_fence_i;
		logic rv64i_ecall, rv64i_ebreak;
		logic rv64csr_rw, rv64csr_rs, rv64csr_rc, rv64csr_rwi, rv64csr_rsi, rv64csr_rci;
		logic privil_mret;
		logic is_rvc;
	} micro_op_t;

	typedef struct packed {
		micro_op_t               op;
		logic [`XLEN-1:0]        pc;
		logic [`XLEN-1:0]        imm;
		logic [5:0]              shamt;
		logic [`REG_IDX_W-1:0]   rd0;
		logic [`REG_IDX_W-1:0]   rs1;
		logic [`REG_IDX_W-1:0]   rs2;
	} micro_instr_t;

	// what fetch hands to decode
	typedef struct packed {
		instr_word_u      instr;
		logic [`XLEN-1:0] pc;
	} fetch_entry_t;

endpackage

`default_nettype wire

// ==== hdl/decode_consts.svh ====
/*
 * Sizes shared by the decode front end, its package and its testbench.
 * Include wherever a width or depth is needed.
 */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// data path and pc width
`define XLEN 64

// architectural register index
`define REG_IDX_W 5

// default number of micro-instructions buffered ahead of issue
`define INSTR_Q_DEPTH 4

// one-hot flags carried by a micro-instruction, rvc included
`define MICRO_OP_FLAGS 61

`endif
